// File: source/kd_tree_cfg.svh
/*
 kd-tree leaf search configuration
 tree depth and the sizes that follow from it, plus patch geometry
*/
`ifndef KD_TREE_CFG_SVH
`define KD_TREE_CFG_SVH

// levels walked per query, one per clock
`define KD_DEPTH 6

// internal nodes in a full tree of KD_DEPTH levels
`define KD_NODES 63

// leaves reached after the last level
`define KD_LEAVES 64

// coordinates per query patch
`define KD_DIMS 5

// bits per coordinate and per median
`define KD_COORD_W 11

`endif

// File: source/kd_tree_pkg.sv
/*
 kd-tree leaf search types
 coordinates, patches, node words, pipeline stages and leaf results
*/
`default_nettype none

`include "kd_tree_cfg.svh"

package kd_tree_pkg;

    // one patch coordinate, also the width of a median
    typedef logic [`KD_COORD_W-1:0] coord_t;

    // coordinate 0 in the low bits
    typedef coord_t [`KD_DIMS-1:0] patch_t;

    // split dimension, only 0..KD_DIMS-1 is legal
    typedef logic [$clog2(`KD_DIMS)-1:0] dim_t;

    // heap order: root 0, children 2n+1 and 2n+2
    typedef logic [`KD_DEPTH-1:0] node_addr_t;

    // one internal node
    typedef struct packed {
        dim_t   dim;
        coord_t median;
    } node_word_t;

    // whole node table, node 0 in the low bits
    typedef node_word_t [`KD_NODES-1:0] node_table_t;

    // query as it arrives on a lane
    typedef struct packed {
        logic   valid;
        patch_t patch;
    } query_t;

    // pos counts from 0 within the current level
    typedef struct packed {
        logic       valid;
        patch_t     patch;
        node_addr_t pos;
    } stage_t;

    typedef logic [`KD_DEPTH-1:0] leaf_idx_t;

    // search result on a lane
    typedef struct packed {
        logic      valid;
        leaf_idx_t idx;
    } leaf_t;

endpackage

`default_nettype wire

// File: source/kd_node_store.sv
/*
 kd-tree node store
 register table of the internal nodes, loaded either through an
 auto-incrementing pointer or by address, with combinational readback
*/
`timescale 1ns/1ns
`default_nettype none

`include "kd_tree_cfg.svh"

module kd_node_store (
    input  wire                      clk,
    input  wire                      rst_n,
    // sequential load
    input  wire                      load_en_i,
    input  wire kd_tree_pkg::node_word_t load_data_i,
    // addressed write and readback
    input  wire                      cfg_we_i,
    input  wire kd_tree_pkg::node_addr_t cfg_addr_i,
    input  wire kd_tree_pkg::node_word_t cfg_wdata_i,
    output kd_tree_pkg::node_word_t  cfg_rdata_o,
    // whole table to the levels
    output kd_tree_pkg::node_table_t table_o
);

    import kd_tree_pkg::*;

    // last real node, pointer wraps after it
    localparam node_addr_t LAST_NODE = node_addr_t'(`KD_NODES - 1);

    node_table_t table_q;
    node_addr_t  load_ptr_q;

    // resolved write port
    logic        wr_en;
    node_addr_t  wr_addr;
    node_word_t  wr_data;
    logic        ptr_adv;
    logic        cfg_addr_ok;

    // address 63 has no node behind it
    assign cfg_addr_ok = (cfg_addr_i <= LAST_NODE);

    // addressed write wins over the load strobe
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = load_ptr_q;
        wr_data = load_data_i;
        ptr_adv = 1'b0;
        if (cfg_we_i) begin
            // out of range write dropped
            wr_en   = cfg_addr_ok;
            wr_addr = cfg_addr_i;
            wr_data = cfg_wdata_i;
        end else if (load_en_i) begin
            wr_en   = 1'b1;
            ptr_adv = 1'b1;
        end
    end

    // load pointer, holds when the addressed write takes the cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_ptr_q <= '0;
        end else if (ptr_adv) begin
            if (load_ptr_q == LAST_NODE) begin
                load_ptr_q <= '0;
            end else begin
                load_ptr_q <= load_ptr_q + 1'b1;
            end
        end
    end

    // node registers
    // cleared table means dim 0, median 0 everywhere
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            table_q <= '0;
        end else if (wr_en) begin
            table_q[wr_addr] <= wr_data;
        end
    end

    // readback mux, zero for the unused address
    always_comb begin
        cfg_rdata_o = '0;
        if (cfg_addr_ok) begin
            cfg_rdata_o = table_q[cfg_addr_i];
        end
    end

    // every level sees the full table
    assign table_o = table_q;

endmodule

`default_nettype wire

// File: source/kd_tree_level.sv
/*
 kd-tree pipeline level
 for both lanes picks the node on the current path, compares the
 selected coordinate with its median and registers the extended path
*/
`timescale 1ns/1ns
`default_nettype none

`include "kd_tree_cfg.svh"

module kd_tree_level #(
    // 0 is the root level
    parameter int LEVEL = 0
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire kd_tree_pkg::node_table_t table_i,
    // lane a
    input  wire kd_tree_pkg::stage_t  stage_a_i,
    output kd_tree_pkg::stage_t       stage_a_o,
    // lane b
    input  wire kd_tree_pkg::stage_t  stage_b_i,
    output kd_tree_pkg::stage_t       stage_b_o
);

    import kd_tree_pkg::*;

    // heap address of the leftmost node on this level
    localparam node_addr_t BASE = node_addr_t'((1 << LEVEL) - 1);

    stage_t next_a;
    stage_t next_b;

    // one step down the tree for a single lane
    function automatic stage_t descend(input stage_t s, input node_table_t t);
        node_addr_t idx;
        node_word_t node;
        coord_t     coord;
        logic       go_right;
        stage_t     nxt;
        // node on the path at this level
        idx  = BASE + s.pos;
        node = t[idx];
        // illegal dim compares as coordinate 0
        coord = '0;
        if (node.dim < `KD_DIMS) begin
            coord = s.patch[node.dim];
        end
        // equal goes right
        go_right = (coord >= node.median);
        nxt.valid = s.valid;
        nxt.patch = s.patch;
        // pos doubled plus the decision
        nxt.pos   = {s.pos[`KD_DEPTH-2:0], go_right};
        return nxt;
    endfunction

    // both lanes share the table, paths are independent
    always_comb begin
        next_a = descend(stage_a_i, table_i);
        next_b = descend(stage_b_i, table_i);
    end

    // stage registers
    // only the valids are cleared, patch and pos are payload
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_a_o.valid <= 1'b0;
            stage_b_o.valid <= 1'b0;
        end else begin
            // invalid stages move on too, valid stays low
            stage_a_o <= next_a;
            stage_b_o <= next_b;
        end
    end

endmodule

`default_nettype wire

// File: source/kd_leaf_search.sv
/*
 kd-tree leaf search, top level
 two independent query lanes walk a six level tree one level per clock
 and come out as leaf indices; the node table is loaded on the side
*/
`timescale 1ns/1ns
`default_nettype none

`include "kd_tree_cfg.svh"

module kd_leaf_search (
    input  wire                      clk,
    input  wire                      rst_n,
    // query lanes
    input  wire kd_tree_pkg::query_t query_a_i,
    input  wire kd_tree_pkg::query_t query_b_i,
    // sequential load
    input  wire                      load_en_i,
    input  wire kd_tree_pkg::node_word_t load_data_i,
    // addressed write and readback
    input  wire                      cfg_we_i,
    input  wire kd_tree_pkg::node_addr_t cfg_addr_i,
    input  wire kd_tree_pkg::node_word_t cfg_wdata_i,
    output kd_tree_pkg::node_word_t  cfg_rdata_o,
    // results, six edges after the query is sampled
    output kd_tree_pkg::leaf_t       leaf_a_o,
    output kd_tree_pkg::leaf_t       leaf_b_o
);

    import kd_tree_pkg::*;

    node_table_t node_table;

    // input registers
    stage_t in_a_q;
    stage_t in_b_q;

    // stage k feeds level k, stage KD_DEPTH is the leaf
    stage_t stage_a [`KD_DEPTH+1];
    stage_t stage_b [`KD_DEPTH+1];

    // node table
    kd_node_store u_node_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_en_i   (load_en_i),
        .load_data_i (load_data_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .table_o     (node_table)
    );

    // queries enter at the root, pos 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_a_q.valid <= 1'b0;
            in_b_q.valid <= 1'b0;
        end else begin
            in_a_q <= '{valid: query_a_i.valid, patch: query_a_i.patch, pos: '0};
            in_b_q <= '{valid: query_b_i.valid, patch: query_b_i.patch, pos: '0};
        end
    end

    assign stage_a[0] = in_a_q;
    assign stage_b[0] = in_b_q;

    // one level per clock, root first
    for (genvar k = 0; k < `KD_DEPTH; k++) begin : g_level
        kd_tree_level #(
            .LEVEL (k)
        ) u_level (
            .clk       (clk),
            .rst_n     (rst_n),
            .table_i   (node_table),
            .stage_a_i (stage_a[k]),
            .stage_a_o (stage_a[k+1]),
            .stage_b_i (stage_b[k]),
            .stage_b_o (stage_b[k+1])
        );
    end

    // final pos is the leaf number
    always_comb begin
        leaf_a_o.valid = stage_a[`KD_DEPTH].valid;
        leaf_a_o.idx   = stage_a[`KD_DEPTH].pos;
        leaf_b_o.valid = stage_b[`KD_DEPTH].valid;
        leaf_b_o.idx   = stage_b[`KD_DEPTH].pos;
    end

endmodule

`default_nettype wire

// File: testbench/kd_tree_clk_gen.sv
/*
 kd-tree testbench clock and reset
 40 ns clock, active low reset held for five cycles
*/
`timescale 1ns/1ns
`default_nettype none

module kd_tree_clk_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/kd_tree_chk.sv
/*
 kd-tree leaf search checker
 node writes carry a legal split dimension, every query turns into a
 leaf on its own lane, leaf valids stay low in reset
*/
`timescale 1ns/1ns
`default_nettype none

`include "kd_tree_cfg.svh"

module kd_tree_chk (
    input wire                          clk,
    input wire                          rst_n,
    input wire kd_tree_pkg::query_t     query_a_i,
    input wire kd_tree_pkg::query_t     query_b_i,
    input wire                          load_en_i,
    input wire kd_tree_pkg::node_word_t load_data_i,
    input wire                          cfg_we_i,
    input wire kd_tree_pkg::node_word_t cfg_wdata_i,
    input wire kd_tree_pkg::leaf_t      leaf_a_i,
    input wire kd_tree_pkg::leaf_t      leaf_b_i
);

    // leaf written at the sixth edge, sampled at the seventh
    localparam int LEAF_DELAY = `KD_DEPTH + 1;

    // read by the testbench for its summary
    int fail_cnt = 0;

    a_cfg_dim: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_we_i |-> (cfg_wdata_i.dim < `KD_DIMS))
        else begin
            $error("addressed write with split dimension %0d", cfg_wdata_i.dim);
            fail_cnt++;
        end

    a_load_dim: assert property (@(posedge clk) disable iff (!rst_n)
        load_en_i |-> (load_data_i.dim < `KD_DIMS))
        else begin
            $error("sequential load with split dimension %0d", load_data_i.dim);
            fail_cnt++;
        end

    a_lane_a: assert property (@(posedge clk) disable iff (!rst_n)
        query_a_i.valid |-> ##LEAF_DELAY leaf_a_i.valid)
        else begin
            $error("lane a query without a leaf");
            fail_cnt++;
        end

    a_lane_b: assert property (@(posedge clk) disable iff (!rst_n)
        query_b_i.valid |-> ##LEAF_DELAY leaf_b_i.valid)
        else begin
            $error("lane b query without a leaf");
            fail_cnt++;
        end

    // from the second reset cycle the stage valids are cleared
    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n ##1 !rst_n) |-> (!leaf_a_i.valid && !leaf_b_i.valid))
        else begin
            $error("leaf valid high during reset");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: testbench/kd_tree_tb.sv
/*
 kd-tree leaf search testbench
 loads the node table both ways, sends queries on both lanes and checks
 every leaf against its own walk of the tree
*/
`timescale 1ns/1ns
`default_nettype none

`include "kd_tree_cfg.svh"

module kd_tree_tb;

    import kd_tree_pkg::*;

    // a query sampled at edge N has its leaf checked at edge N+7
    localparam int PIPE_EDGES = `KD_DEPTH + 1;
    localparam int DRAIN = PIPE_EDGES + 1;
    localparam int RUN_LEN = 200;
    // reset and tests 1 to 6 in cycles plus a margin
    localparam int CYCLE_LIMIT = (6 + 84 + 1373 + 202 + 271 + 208 + 151) + 500;

    logic        clk;
    logic        rst_n;
    query_t      query_a;
    query_t      query_b;
    logic        load_en;
    node_word_t  load_data;
    logic        cfg_we;
    node_addr_t  cfg_addr;
    node_word_t  cfg_wdata;
    node_word_t  cfg_rdata;
    leaf_t       leaf_a;
    leaf_t       leaf_b;

    // own copy of the table and the load pointer
    node_table_t model_tbl;
    int          model_ptr;
    // expected leaves in flight per lane
    leaf_t       want_a[$];
    leaf_t       want_b[$];

    int errors = 0;
    int checks = 0;
    int results = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_cnt = 0;
    int err_mark;
    int res_mark;

    kd_tree_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    kd_leaf_search UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .query_a_i   (query_a),
        .query_b_i   (query_b),
        .load_en_i   (load_en),
        .load_data_i (load_data),
        .cfg_we_i    (cfg_we),
        .cfg_addr_i  (cfg_addr),
        .cfg_wdata_i (cfg_wdata),
        .cfg_rdata_o (cfg_rdata),
        .leaf_a_o    (leaf_a),
        .leaf_b_o    (leaf_b)
    );

    bind kd_leaf_search kd_tree_chk u_chk (
        .clk (clk), .rst_n (rst_n),
        .query_a_i (query_a_i), .query_b_i (query_b_i),
        .load_en_i (load_en_i), .load_data_i (load_data_i),
        .cfg_we_i (cfg_we_i), .cfg_wdata_i (cfg_wdata_i),
        .leaf_a_i (leaf_a_o), .leaf_b_i (leaf_b_o)
    );

    // heap walk with children 2n+1 left and 2n+2 right
    function automatic leaf_idx_t kd_walk(input node_table_t t, input patch_t p);
        int         n;
        node_word_t w;
        coord_t     c;
        n = 0;
        for (int lvl = 0; lvl < `KD_DEPTH; lvl++) begin
            w = t[n];
            c = (w.dim < `KD_DIMS) ? p[w.dim] : '0;
            n = (c >= w.median) ? 2 * n + 2 : 2 * n + 1;
        end
        return leaf_idx_t'(n - `KD_NODES);
    endfunction

    function automatic patch_t rand_patch();
        patch_t p;
        for (int d = 0; d < `KD_DIMS; d++) begin
            p[d] = coord_t'($urandom_range(0, (1 << `KD_COORD_W) - 1));
        end
        return p;
    endfunction

    // level_dim picks the split dimension from the node's level and a nonzero median
    function automatic node_word_t rand_word(input logic level_dim, input int n);
        node_word_t w;
        w.dim = dim_t'($urandom_range(0, `KD_DIMS - 1));
        w.median = coord_t'($urandom_range(0, (1 << `KD_COORD_W) - 1));
        if (level_dim) begin
            w.dim = dim_t'(($clog2(n + 2) - 1) % `KD_DIMS);
            w.median = coord_t'($urandom_range(1, (1 << `KD_COORD_W) - 1));
        end
        return w;
    endfunction

    task automatic compare_leaf(input string lane, input leaf_t want, input leaf_t got);
        checks++;
        assert (got.valid === want.valid) else begin
            $display("CHECK FAILED at %0t ns: lane %s valid %b, expected %b",
                     $time, lane, got.valid, want.valid);
            errors++;
        end
        if (want.valid) begin
            checks++;
            results++;
            assert (got.idx === want.idx) else begin
                $display("CHECK FAILED at %0t ns: lane %s leaf %0d, expected %0d",
                         $time, lane, got.idx, want.idx);
                errors++;
            end
        end
    endtask

    // inputs and outputs both steady at the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            want_a.delete();
            want_b.delete();
        end else begin
            if (want_a.size() == PIPE_EDGES) begin
                compare_leaf("a", want_a.pop_front(), leaf_a);
            end
            if (want_b.size() == PIPE_EDGES) begin
                compare_leaf("b", want_b.pop_front(), leaf_b);
            end
            want_a.push_back('{valid: query_a.valid,
                               idx: query_a.valid ? kd_walk(model_tbl, query_a.patch) : '0});
            want_b.push_back('{valid: query_b.valid,
                               idx: query_b.valid ? kd_walk(model_tbl, query_b.patch) : '0});
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // one config cycle with the model following write-over-load priority
    task automatic drive_cfg(input logic we, input node_addr_t a, input node_word_t w,
                             input logic ld, input node_word_t lw);
        @(negedge clk);
        query_a.valid = 1'b0;
        query_b.valid = 1'b0;
        cfg_we = we;
        cfg_addr = a;
        cfg_wdata = w;
        load_en = ld;
        load_data = lw;
        if (we) begin
            if (a < `KD_NODES) begin
                model_tbl[a] = w;
            end
        end else if (ld) begin
            model_tbl[model_ptr] = lw;
            model_ptr = (model_ptr + 1) % `KD_NODES;
        end
    endtask

    task automatic send_queries(input logic va, input patch_t pa, input logic vb, input patch_t pb);
        @(negedge clk);
        cfg_we = 1'b0;
        load_en = 1'b0;
        query_a = '{valid: va, patch: pa};
        query_b = '{valid: vb, patch: pb};
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            send_queries(1'b0, '0, 1'b0, '0);
        end
    endtask

    // whole table plus the empty address 63
    task automatic check_table();
        node_word_t want;
        for (int a = 0; a <= `KD_NODES; a++) begin
            want = (a < `KD_NODES) ? model_tbl[a] : '0;
            drive_cfg(1'b0, node_addr_t'(a), '0, 1'b0, '0);
            @(posedge clk);
            checks++;
            assert (cfg_rdata === want) else begin
                $display("CHECK FAILED at %0t ns: node %0d reads %h, expected %h",
                         $time, a, cfg_rdata, want);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name);
        int n_err;
        idle(DRAIN);
        n_err = errors - err_mark;
        tests_run++;
        if (n_err != 0) begin
            tests_failed++;
        end
        $display("test %0d %-12s %s, %0d leaves compared, %0d errors", tests_run, name,
                 (n_err == 0) ? "ok" : "FAILED", results - res_mark, n_err);
        err_mark = errors;
        res_mark = results;
    endtask

    initial begin : stimulus
        logic [`KD_DEPTH-2:0] path;
        logic                 go_right;
        int                   n;
        node_word_t           w;
        patch_t               p;
        void'($urandom(69));
        query_a = '0;
        query_b = '0;
        load_en = 1'b0;
        load_data = '0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        model_tbl = '0;
        model_ptr = 0;
        err_mark = 0;
        res_mark = 0;
        wait (rst_n === 1'b1);

        // cleared table sends every query right to leaf 63
        check_table();
        repeat (12) send_queries(1'b1, rand_patch(), 1'b1, rand_patch());
        end_test("reset");

        for (int i = 0; i < 20; i++) begin
            n = $urandom_range(0, `KD_NODES - 1);
            drive_cfg(1'b1, node_addr_t'(n), rand_word(1'b0, 0), 1'b0, '0);
            check_table();
        end
        drive_cfg(1'b1, node_addr_t'(`KD_NODES), rand_word(1'b0, 0), 1'b0, '0);
        check_table();
        end_test("addr_write");

        repeat (`KD_NODES) drive_cfg(1'b0, '0, '0, 1'b1, rand_word(1'b0, 0));
        check_table();
        // 64th load wraps onto node 0
        drive_cfg(1'b0, '0, '0, 1'b1, rand_word(1'b0, 0));
        // with both strobes high the load is dropped and the pointer stays at 1
        n = $urandom_range(8, `KD_NODES - 1);
        drive_cfg(1'b1, node_addr_t'(n), rand_word(1'b0, 0), 1'b1, rand_word(1'b0, 0));
        drive_cfg(1'b0, '0, '0, 1'b1, rand_word(1'b0, 0));
        check_table();
        end_test("seq_load");

        repeat (`KD_NODES) drive_cfg(1'b0, '0, '0, 1'b1, rand_word(1'b0, 0));
        repeat (RUN_LEN) send_queries(1'b1, rand_patch(), 1'b1, rand_patch());
        end_test("full_rate");

        repeat (RUN_LEN) begin
            send_queries(1'($urandom_range(0, 1)), rand_patch(),
                         1'($urandom_range(0, 1)), rand_patch());
        end
        end_test("bubbles");

        // split dims follow the level and level 5 reuses dim 0
        repeat (`KD_NODES) drive_cfg(1'b0, '0, '0, 1'b1, rand_word(1'b1, model_ptr));
        for (int t = 0; t < 8; t++) begin
            path = ($urandom_range(0, (1 << (`KD_DEPTH - 1)) - 1));
            p = '0;
            n = 0;
            for (int lvl = 0; lvl < `KD_DEPTH - 1; lvl++) begin
                go_right = path[`KD_DEPTH - 2 - lvl];
                w = model_tbl[n];
                p[w.dim] = go_right ? w.median : w.median - 1'b1;
                n = go_right ? 2 * n + 2 : 2 * n + 1;
            end
            // last node on the path gets a median equal to its coordinate
            w = model_tbl[n];
            w.median = p[w.dim];
            drive_cfg(1'b1, node_addr_t'(n), w, 1'b0, '0);
            send_queries(1'b1, p, 1'b1, p);
            checks++;
            assert (kd_walk(model_tbl, p) == {path, 1'b1}) else begin
                $display("CHECK FAILED at %0t ns: path %b does not end on its right leaf",
                         $time, path);
                errors++;
            end
            idle(DRAIN);
        end
        end_test("median_eq");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, checks, errors, UUT.u_chk.fail_cnt);
        if (errors == 0 && tests_failed == 0 && UUT.u_chk.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: kd_tree.f
+incdir+source
source/kd_tree_pkg.sv
source/kd_node_store.sv
source/kd_tree_level.sv
source/kd_leaf_search.sv
testbench/kd_tree_clk_gen.sv
testbench/kd_tree_chk.sv
testbench/kd_tree_tb.sv
